//--- tb.f
+incdir+include
rtl/decode_pkg.sv
rtl/ctrl_decoder.sv
rtl/greg_file.sv
rtl/pred_file.sv
rtl/imm_extend.sv
rtl/decode_stage.sv
dv/decode_assertions.sv
dv/decode_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/decode_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

//--- dv/decode_tb.sv
`include "decode_config.svh"

module decode_tb
  import decode_pkg::*;
();

  logic      clk;
  logic      rst;
  word_t     inst;
  logic      wb_greg_en;
  greg_idx_t wb_greg_idx;
  word_t     wb_greg_data;
  logic      wb_preg_en;
  preg_idx_t wb_preg_idx;
  logic      wb_preg_data;
  word_t     rx;
  word_t     ry;
  word_t     imm;
  logic      px;
  logic      py;
  logic      guard;
  greg_idx_t dst_idx;
  alu_op_e   alu_op;
  logic      src2_imm;
  logic      int_op;
  logic      link;
  logic      mem_read;
  logic      mem_write;
  logic      wb_from_mem;
  logic      wb_greg;
  logic      wb_preg;

  word_t              shadow_g [`GREG_N];
  logic [`PREG_N-1:0] shadow_p;
  alu_op_e            e_alu;
  logic [7:0]         e_ctrl; // src2_imm int_op link mem_read mem_write wb_from_mem wb_greg wb_preg
  word_t              e_imm;
  word_t              e_rx;
  word_t              e_ry;
  greg_idx_t          e_dst;
  logic               e_px;
  logic               e_py;
  logic               e_guard;
  logic [31:0]        lcg_state = 32'd56210;
  int                 word_errs = 0;
  int                 idx_errs = 0;
  int                 alu_errs = 0;
  int                 bit_errs = 0;
  int                 other_errs = 0;
  int                 checks = 0;

  opcode_e kept_ops [32] = '{op_neg, op_not, op_and, op_or, op_xor, op_add, op_sub, op_mul,
                             op_div, op_mod, op_shl, op_shr, op_andi, op_ori, op_xori, op_addi,
                             op_subi, op_muli, op_divi, op_modi, op_shli, op_shri, op_ld, op_st,
                             op_ldi, op_rtop, op_andp, op_orp, op_xorp, op_pnot, op_isneg,
                             op_iszero};

  decode_stage decode_stage_inst (.*);

  bind decode_stage decode_assertions decode_assertions_inst (
    .clk       (clk),
    .rst       (rst),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .wb_greg   (wb_greg),
    .wb_preg   (wb_preg),
    .src2_imm  (src2_imm)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16]; // upper half, low bits cycle fast
  endfunction

  function automatic word_t rand_word();
    logic [15:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  function automatic alu_op_e expected_alu(input opcode_e opc);
    case (opc)
      op_ld, op_st, op_add, op_addi: return alu_add_andp;
      op_sub, op_subi:               return alu_sub_orp;
      op_mul, op_muli:               return alu_mul_xorp;
      op_div, op_divi:               return alu_div_pnot;
      op_mod, op_modi:               return alu_mod_rtop;
      op_shl, op_shli:               return alu_shl_isneg;
      op_shr, op_shri:               return alu_shr_iszero;
      op_and, op_andi:               return alu_and;
      op_or, op_ori:                 return alu_or;
      op_xor, op_xori:               return alu_xor;
      op_neg:                        return alu_neg;
      op_not:                        return alu_not;
      op_ldi:                        return alu_pass_imm;
      op_andp:                       return alu_add_andp;
      op_orp:                        return alu_sub_orp;
      op_xorp:                       return alu_mul_xorp;
      op_pnot:                       return alu_div_pnot;
      op_rtop:                       return alu_mod_rtop;
      op_isneg:                      return alu_shl_isneg;
      op_iszero:                     return alu_shr_iszero;
      default:                       return alu_none;
    endcase
  endfunction

  task automatic reset_model();
    for (int i = 0; i < `GREG_N; i++)
      shadow_g[i] = word_t'(i);
    shadow_p = 4'b0011;
  endtask

  task automatic predict_decode(input word_t w);
    opcode_e   opc;
    greg_idx_t xi;
    greg_idx_t yi;
    greg_idx_t zi;
    opc = opcode_e'(w[`OPC_MSB:`OPC_LSB]);
    xi = w[`X_LSB +: `GREG_IDX_W];
    yi = w[`Y_LSB +: `GREG_IDX_W];
    zi = w[`Z_LSB +: `GREG_IDX_W];
    if (opc == op_st)
      xi = zi; // store data register
    e_dst = zi;
    e_rx = shadow_g[xi];
    e_ry = shadow_g[yi];
    e_px = shadow_p[xi[1:0]];
    e_py = shadow_p[yi[1:0]];
    e_guard = w[`PSET_BIT] ? shadow_p[w[`PID_LSB +: `PREG_IDX_W]] : 1'b1;
    case (opc)
      op_ld:  e_ctrl = 8'b1101_0110;
      op_st:  e_ctrl = 8'b1100_1000;
      op_ldi: e_ctrl = 8'b1100_0010;
      op_rtop, op_andp, op_orp, op_xorp, op_pnot, op_isneg, op_iszero:
        e_ctrl = 8'b0000_0001;
      op_andi, op_ori, op_xori, op_addi, op_subi, op_muli, op_divi, op_modi, op_shli, op_shri:
        e_ctrl = 8'b1100_0010;
      op_neg, op_not, op_and, op_or, op_xor, op_add, op_sub, op_mul, op_div, op_mod, op_shl,
      op_shr:
        e_ctrl = 8'b0100_0010;
      default: e_ctrl = 8'b0;
    endcase
    e_imm = '0;
    if (opc == op_ldi)
      e_imm = word_t'($signed({w[18:0], 13'd0}) >>> 13);
    else if (e_ctrl[7])
      e_imm = word_t'($signed({w[14:0], 17'd0}) >>> 17); // every other src2_imm op
    e_alu = expected_alu(opc);
  endtask

  task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      word_errs++;
      $display("ERR %s exp=%h act=%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_idx(input string name, input greg_idx_t exp_v, input greg_idx_t act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      idx_errs++;
      $display("ERR %s exp=%h act=%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e exp_v, input alu_op_e act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      alu_errs++;
      $display("ERR %s exp=%h act=%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v)
    begin
      bit_errs++;
      $display("ERR %s exp=%h act=%h", name, exp_v, act_v);
    end
  endtask

  task automatic check_outputs(input word_t w);
    predict_decode(w);
    check_word("rx", e_rx, rx);
    check_word("ry", e_ry, ry);
    check_word("imm", e_imm, imm);
    check_idx("dst_idx", e_dst, dst_idx);
    check_alu("alu_op", e_alu, alu_op);
    check_bit("px", e_px, px);
    check_bit("py", e_py, py);
    check_bit("guard", e_guard, guard);
    check_bit("src2_imm", e_ctrl[7], src2_imm);
    check_bit("int_op", e_ctrl[6], int_op);
    check_bit("link", e_ctrl[5], link);
    check_bit("mem_read", e_ctrl[4], mem_read);
    check_bit("mem_write", e_ctrl[3], mem_write);
    check_bit("wb_from_mem", e_ctrl[2], wb_from_mem);
    check_bit("wb_greg", e_ctrl[1], wb_greg);
    check_bit("wb_preg", e_ctrl[0], wb_preg);
  endtask

  // write lands on the next edge, so the check still sees the old contents
  task automatic drive_and_check(input word_t w, input logic ge, input greg_idx_t gi,
                                 input word_t gd, input logic pe, input preg_idx_t pi,
                                 input logic pd);
    @(posedge clk);
    inst <= w;
    wb_greg_en <= ge;
    wb_greg_idx <= gi;
    wb_greg_data <= gd;
    wb_preg_en <= pe;
    wb_preg_idx <= pi;
    wb_preg_data <= pd;
    @(negedge clk);
    check_outputs(w);
    if (ge)
      shadow_g[gi] = gd;
    if (pe)
      shadow_p[pi] = pd;
  endtask

  task automatic wait_reset_release(output logic released);
    int cyc;
    cyc = 0;
    while (rst !== 1'b0 && cyc < 10)
    begin
      @(negedge clk);
      cyc++;
    end
    released = (rst === 1'b0);
  endtask

  task automatic run_tests();
    word_t       w;
    logic [15:0] r;
    logic [15:0] r2;
    for (int i = 0; i < `GREG_N; i++)
    begin
      w = '0; // nop with guard enabled
      w[`X_LSB +: `GREG_IDX_W] = greg_idx_t'(i);
      w[`Y_LSB +: `GREG_IDX_W] = greg_idx_t'(`GREG_N - 1 - i);
      w[`PID_LSB +: `PREG_IDX_W] = preg_idx_t'(i);
      w[`PSET_BIT] = 1'b1;
      drive_and_check(w, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    end
    for (int k = 0; k < `GREG_N; k++)
    begin
      w = '0;
      w[`X_LSB +: `GREG_IDX_W] = greg_idx_t'(k);
      drive_and_check(w, 1'b1, greg_idx_t'(k), rand_word(), 1'b1, preg_idx_t'(k),
                      ~shadow_p[k[1:0]]);
      drive_and_check(w, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    end
    for (int o = 0; o < 64; o++)
    begin
      w = rand_word();
      w[`OPC_MSB:`OPC_LSB] = 6'(o);
      drive_and_check(w, 1'b0, '0, '0, 1'b0, '0, 1'b0);
    end
    for (int n = 0; n < 2000; n++)
    begin
      w = rand_word();
      r = next_rand();
      r2 = next_rand();
      if (r[15])
        w[`OPC_MSB:`OPC_LSB] = kept_ops[r[4:0]];
      else
        w[`OPC_MSB:`OPC_LSB] = r[10:5];
      drive_and_check(w, r2[15], r2[3:0], rand_word(), r2[14], r2[5:4], r2[13]);
    end
  endtask

  task automatic finish_run();
    int assert_errs;
    int total;
    assert_errs = decode_stage_inst.decode_assertions_inst.fail_count;
    total = word_errs + idx_errs + alu_errs + bit_errs + assert_errs + other_errs;
    $display("checks=%0d errors: word=%0d idx=%0d alu=%0d bit=%0d assert=%0d other=%0d",
             checks, word_errs, idx_errs, alu_errs, bit_errs, assert_errs, other_errs);
    if (total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  initial
  begin
    logic released;
    rst <= 1'b1;
    inst <= '0;
    wb_greg_en <= 1'b0;
    wb_greg_idx <= '0;
    wb_greg_data <= '0;
    wb_preg_en <= 1'b0;
    wb_preg_idx <= '0;
    wb_preg_data <= 1'b0;
    reset_model();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait_reset_release(released);
    if (released)
      run_tests();
    else
    begin
      other_errs++;
      $display("reset was not released within 10 cycles");
    end
    finish_run();
  end

endmodule

//--- dv/decode_assertions.sv
module decode_assertions
(
  input logic clk,
  input logic rst,
  input logic mem_read,
  input logic mem_write,
  input logic wb_greg,
  input logic wb_preg,
  input logic src2_imm
);

  int fail_count = 0; // read by the testbench at the end

  mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
    else
    begin
      fail_count++;
      $error("mem_read and mem_write high together");
    end

  wb_excl: assert property (@(posedge clk) disable iff (rst) !(wb_greg && wb_preg))
    else
    begin
      fail_count++;
      $error("wb_greg and wb_preg high together");
    end

  // store address is base plus offset
  st_imm: assert property (@(posedge clk) disable iff (rst) mem_write |-> src2_imm)
    else
    begin
      fail_count++;
      $error("mem_write without src2_imm");
    end

endmodule

//--- rtl/decode_stage.sv
`include "decode_config.svh"

module decode_stage
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  word_t     inst,
  input  logic      wb_greg_en,
  input  greg_idx_t wb_greg_idx,
  input  word_t     wb_greg_data,
  input  logic      wb_preg_en,
  input  preg_idx_t wb_preg_idx,
  input  logic      wb_preg_data,
  output word_t     rx,
  output word_t     ry,
  output logic      px,
  output logic      py,
  output logic      guard,
  output word_t     imm,
  output greg_idx_t dst_idx,
  output alu_op_e   alu_op,
  output logic      src2_imm,
  output logic      int_op,
  output logic      link,
  output logic      mem_read,
  output logic      mem_write,
  output logic      wb_from_mem,
  output logic      wb_greg,
  output logic      wb_preg
);

  greg_idx_t rx_idx;
  greg_idx_t ry_idx;
  preg_idx_t pid;
  logic      pset;
  ext_sel_e  ext_sel;

  ctrl_decoder ctrl_decoder_inst (
    .inst        (inst),
    .rx_idx      (rx_idx),
    .ry_idx      (ry_idx),
    .dst_idx     (dst_idx),
    .pid         (pid),
    .pset        (pset),
    .ext_sel     (ext_sel),
    .alu_op      (alu_op),
    .src2_imm    (src2_imm),
    .int_op      (int_op),
    .link        (link),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .wb_from_mem (wb_from_mem),
    .wb_greg     (wb_greg),
    .wb_preg     (wb_preg)
  );

  greg_file greg_file_inst (
    .clk     (clk),
    .rst     (rst),
    .rx_idx  (rx_idx),
    .ry_idx  (ry_idx),
    .wr_idx  (wb_greg_idx),
    .wr_en   (wb_greg_en),
    .wr_data (wb_greg_data),
    .rx      (rx),
    .ry      (ry)
  );

  // predicate reads reuse the low bits of the general indices
  pred_file pred_file_inst (
    .clk     (clk),
    .rst     (rst),
    .px_idx  (rx_idx[`PREG_IDX_W-1:0]),
    .py_idx  (ry_idx[`PREG_IDX_W-1:0]),
    .pid     (pid),
    .wr_idx  (wb_preg_idx),
    .pset    (pset),
    .wr_en   (wb_preg_en),
    .wr_data (wb_preg_data),
    .px      (px),
    .py      (py),
    .guard   (guard)
  );

  imm_extend imm_extend_inst (
    .ext_sel (ext_sel),
    .field   (inst[`IMM_FIELD_W-1:0]),
    .imm     (imm)
  );

endmodule

//--- rtl/imm_extend.sv
`include "decode_config.svh"

module imm_extend
  import decode_pkg::*;
(
  input  ext_sel_e                 ext_sel,
  input  logic [`IMM_FIELD_W-1:0]  field,
  output word_t                    imm
);

  always_comb
  begin
    case (ext_sel)
      ext_simm15:
      begin
        imm = {{(`WORD_W-15){field[14]}}, field[14:0]};
      end
      ext_simm23:
      begin
        imm = {{(`WORD_W-23){field[22]}}, field[22:0]};
      end
      ext_simm19:
      begin
        imm = {{(`WORD_W-19){field[18]}}, field[18:0]}; // ldi
      end
      default:
      begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- rtl/pred_file.sv
`include "decode_config.svh"

module pred_file
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  preg_idx_t px_idx,
  input  preg_idx_t py_idx,
  input  preg_idx_t pid,
  input  preg_idx_t wr_idx,
  input  logic      pset,
  input  logic      wr_en,
  input  logic      wr_data,
  output logic      px,
  output logic      py,
  output logic      guard
);

  logic [`PREG_N-1:0] pregs;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pregs <= {{(`PREG_N-2){1'b0}}, 2'b11}; // p0 and p1 true
    end
    else if (wr_en)
    begin
      pregs[wr_idx] <= wr_data;
    end
  end

  assign px = pregs[px_idx];
  assign py = pregs[py_idx];

  // unguarded instructions always execute
  assign guard = pset ? pregs[pid] : 1'b1;

endmodule

//--- rtl/greg_file.sv
`include "decode_config.svh"

module greg_file
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  greg_idx_t rx_idx,
  input  greg_idx_t ry_idx,
  input  greg_idx_t wr_idx,
  input  logic      wr_en,
  input  word_t     wr_data,
  output word_t     rx,
  output word_t     ry
);

  word_t gregs [`GREG_N];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `GREG_N; i++)
      begin
        gregs[i] <= word_t'(i); // reg i starts at i
      end
    end
    else if (wr_en)
    begin
      gregs[wr_idx] <= wr_data;
    end
  end

  // same-cycle read of wr_idx sees the old value
  assign rx = gregs[rx_idx];
  assign ry = gregs[ry_idx];

endmodule

//--- rtl/ctrl_decoder.sv
`include "decode_config.svh"

module ctrl_decoder
  import decode_pkg::*;
(
  input  word_t     inst,
  output greg_idx_t rx_idx,
  output greg_idx_t ry_idx,
  output greg_idx_t dst_idx,
  output preg_idx_t pid,
  output logic      pset,
  output ext_sel_e  ext_sel,
  output alu_op_e   alu_op,
  output logic      src2_imm,
  output logic      int_op,
  output logic      link,
  output logic      mem_read,
  output logic      mem_write,
  output logic      wb_from_mem,
  output logic      wb_greg,
  output logic      wb_preg
);

  opcode_e   opcode;
  greg_idx_t x_field;
  greg_idx_t z_field;

  assign opcode  = opcode_e'(inst[`OPC_MSB:`OPC_LSB]);
  assign x_field = inst[`X_LSB +: `GREG_IDX_W];
  assign z_field = inst[`Z_LSB +: `GREG_IDX_W];

  assign ry_idx  = inst[`Y_LSB +: `GREG_IDX_W];
  assign dst_idx = z_field;
  assign rx_idx  = (opcode == op_st) ? z_field : x_field; // st reads its data reg from z
  assign pid     = inst[`PID_LSB +: `PREG_IDX_W];
  assign pset    = inst[`PSET_BIT];

  // instruction class bits
  always_comb
  begin
    ext_sel     = ext_none;
    src2_imm    = 1'b0;
    int_op      = 1'b0;
    link        = 1'b0; // no jumps decoded here
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    wb_from_mem = 1'b0;
    wb_greg     = 1'b0;
    wb_preg     = 1'b0;
    case (opcode)
      op_ld:
      begin
        wb_greg     = 1'b1;
        wb_from_mem = 1'b1;
        mem_read    = 1'b1;
        src2_imm    = 1'b1;
        int_op      = 1'b1;
        ext_sel     = ext_simm15;
      end
      op_st:
      begin
        mem_write = 1'b1;
        src2_imm  = 1'b1;
        int_op    = 1'b1;
        ext_sel   = ext_simm15;
      end
      op_rtop, op_andp, op_orp, op_xorp, op_pnot, op_isneg, op_iszero:
      begin
        wb_preg = 1'b1;
      end
      op_andi, op_ori, op_xori, op_addi, op_subi,
      op_muli, op_divi, op_modi, op_shli, op_shri:
      begin
        wb_greg  = 1'b1;
        src2_imm = 1'b1;
        int_op   = 1'b1;
        ext_sel  = ext_simm15;
      end
      op_ldi:
      begin
        wb_greg  = 1'b1;
        src2_imm = 1'b1;
        int_op   = 1'b1;
        ext_sel  = ext_simm19;
      end
      op_neg, op_not, op_and, op_or, op_xor, op_add,
      op_sub, op_mul, op_div, op_mod, op_shl, op_shr:
      begin
        wb_greg = 1'b1;
        int_op  = 1'b1;
      end
      default:
      begin
        wb_greg = 1'b0; // nop and unknown opcodes
      end
    endcase
  end

  always_comb
  begin
    case (opcode)
      op_ld, op_st, op_addi, op_add, op_andp: alu_op = alu_add_andp;
      op_subi, op_sub, op_orp:                alu_op = alu_sub_orp;
      op_muli, op_mul, op_xorp:               alu_op = alu_mul_xorp;
      op_divi, op_div, op_pnot:               alu_op = alu_div_pnot;
      op_modi, op_mod, op_rtop:               alu_op = alu_mod_rtop;
      op_shli, op_shl, op_isneg:              alu_op = alu_shl_isneg;
      op_shri, op_shr, op_iszero:             alu_op = alu_shr_iszero;
      op_andi, op_and:                        alu_op = alu_and;
      op_ori, op_or:                          alu_op = alu_or;
      op_xori, op_xor:                        alu_op = alu_xor;
      op_neg:                                 alu_op = alu_neg;
      op_not:                                 alu_op = alu_not;
      op_ldi:                                 alu_op = alu_pass_imm;
      default:                                alu_op = alu_none;
    endcase
  end

endmodule

//--- rtl/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`GREG_IDX_W-1:0] greg_idx_t;
  typedef logic [`PREG_IDX_W-1:0] preg_idx_t;

  typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
    // register integer ops
    op_neg    = 6'h05,
    op_not    = 6'h06,
    op_and    = 6'h07,
    op_or     = 6'h08,
    op_xor    = 6'h09,
    op_add    = 6'h0a,
    op_sub    = 6'h0b,
    op_mul    = 6'h0c,
    op_div    = 6'h0d,
    op_mod    = 6'h0e,
    op_shl    = 6'h0f,
    op_shr    = 6'h10,
    // immediate integer ops
    op_andi   = 6'h11,
    op_ori    = 6'h12,
    op_xori   = 6'h13,
    op_addi   = 6'h14,
    op_subi   = 6'h15,
    op_muli   = 6'h16,
    op_divi   = 6'h17,
    op_modi   = 6'h18,
    op_shli   = 6'h19,
    op_shri   = 6'h1a,
    // memory and immediate load
    op_ld     = 6'h23,
    op_st     = 6'h24,
    op_ldi    = 6'h25,
    // predicate logic and value test
    op_rtop   = 6'h26,
    op_andp   = 6'h27,
    op_orp    = 6'h28,
    op_xorp   = 6'h29,
    op_pnot   = 6'h2a,
    op_isneg  = 6'h2b,
    op_iszero = 6'h2c
  } opcode_e;

  // integer and predicate ops share codes 1..7, int_op tells them apart
  typedef enum logic [3:0] {
    alu_none       = 4'd0,
    alu_add_andp   = 4'd1,
    alu_sub_orp    = 4'd2,
    alu_mul_xorp   = 4'd3,
    alu_div_pnot   = 4'd4,
    alu_mod_rtop   = 4'd5,
    alu_shl_isneg  = 4'd6,
    alu_shr_iszero = 4'd7,
    alu_and        = 4'd8,
    alu_or         = 4'd9,
    alu_xor        = 4'd10,
    alu_neg        = 4'd11,
    alu_not        = 4'd12,
    alu_pass_imm   = 4'd13
  } alu_op_e;

  typedef enum logic [1:0] {
    ext_none   = 2'd0,
    ext_simm15 = 2'd1,
    ext_simm23 = 2'd2,
    ext_simm19 = 2'd3
  } ext_sel_e;

endpackage

//--- include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// data path
`define WORD_W 32

// register files
`define GREG_N 16
`define PREG_N 4
`define GREG_IDX_W 4
`define PREG_IDX_W 2

// opcode field, inst[28:23]
`define OPC_LSB 23
`define OPC_MSB 28

// register index fields, each GREG_IDX_W wide
`define Z_LSB 19
`define Y_LSB 15
`define X_LSB 11

// guard predicate select
`define PID_LSB 29
`define PSET_BIT 31

// low instruction bits seen by the immediate extender
`define IMM_FIELD_W 23

`endif
